// ==== source/zxreg_consts.svh ====
`ifndef ZXREG_CONSTS_SVH
`define ZXREG_CONSTS_SVH

// ------------------------------------------------------------
// I/O port numbers
// ------------------------------------------------------------

// Register select, read back as the current index
`define ZXREG_ADDR_PORT 16'hFC3B
// Access to whichever register is selected
`define ZXREG_DATA_PORT 16'hFD3B

// ------------------------------------------------------------
// Register indices
// ------------------------------------------------------------

`define ZXREG_IDX_SCANDBL    8'h0B
`define ZXREG_IDX_RASTERLINE 8'h0C
`define ZXREG_IDX_RASTERCTRL 8'h0D
`define ZXREG_IDX_DEVOPTIONS 8'h0E
`define ZXREG_IDX_COREID     8'hFF

// Read value for any index with no register behind it
`define ZXREG_UNMAPPED 8'hFF

// Core-ID string length, no terminator so the pointer just wraps
`define ZXREG_COREID_LEN 8

`endif

// ==== source/zxreg_pkg.sv ====
`default_nettype none

`include "zxreg_consts.svh"

package zxreg_pkg;

   // CPU side of one Z80 I/O bus sample
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
   } bus_cycle_t;

   typedef enum logic [1:0] {
      BS_IDLE,
      BS_READ,
      BS_WRITE,
      BS_WAIT_END
   } bus_state_t;

   // Strobes and levels from the bus FSM to the register file
   typedef struct packed {
      logic       addr_wr;
      logic       data_wr;
      logic       data_rd_done;
      logic       rd_addr_port;
      logic       rd_data_port;
      logic [7:0] wdata;
   } reg_access_t;

   typedef struct packed {
      logic disable_ay;
      logic disable_turboay;
      logic disable_7ffd;
      logic disable_1ffd;
      logic disable_romsel7f;
      logic disable_romsel1f;
      logic enable_timexmmu;
      logic disable_spisd;
   } dev_options_t;

   // Scandoubler control, bit 4 is kept only for readback
   typedef struct packed {
      logic [1:0] turbo_enable;
      logic       csync_option;
      logic       spare;
      logic [1:0] freq_option;
      logic       vga_enable;
      logic       scanlines_enable;
   } video_ctrl_t;

   typedef struct packed {
      logic [8:0] raster_line;
      logic       rasterint_enable;
      logic       vretraceint_disable;
   } raster_cfg_t;

   // First character sits in the top byte
   typedef logic [8*`ZXREG_COREID_LEN-1:0] coreid_table_t;

   localparam coreid_table_t coreid_text = "ZXREG1.0";

endpackage

`default_nettype wire

// ==== source/bus_cycle_fsm.sv ====
`default_nettype none

`include "zxreg_consts.svh"

module bus_cycle_fsm
   import zxreg_pkg::*;
(
   input  wire              clk28,
   input  wire              arst_n,
   input  wire bus_cycle_t  bus,
   output reg_access_t      access,
   output logic [7:0]       reg_addr,
   output logic             regaddr_changed
);

   bus_state_t state;

   logic       hit_addr_port;
   logic       hit_data_port;
   logic       rd_req;
   logic       wr_req;
   logic       start_wr;
   logic       start_rd;

   // Remembers which of the two ports the current cycle is for
   logic       sel_addr_q;
   logic       addr_wr_q;
   logic       data_wr_q;
   logic       rd_done_q;
   logic       rd_addr_q;
   logic       rd_data_q;
   logic [7:0] wdata_q;
   logic [7:0] reg_addr_q;

   // ------------------------------------------------------------
   // Port decode
   // ------------------------------------------------------------
   assign hit_addr_port = (bus.addr == `ZXREG_ADDR_PORT);
   assign hit_data_port = (bus.addr == `ZXREG_DATA_PORT);

   // Exactly one of rd_n and wr_n low
   assign rd_req = !bus.iorq_n && !bus.rd_n && bus.wr_n;
   assign wr_req = !bus.iorq_n && !bus.wr_n && bus.rd_n;

   assign start_wr = (state == BS_IDLE) && wr_req && (hit_addr_port || hit_data_port);
   assign start_rd = (state == BS_IDLE) && rd_req && (hit_addr_port || hit_data_port);

   // ------------------------------------------------------------
   // I/O cycle tracking
   // ------------------------------------------------------------
   always_ff @(posedge clk28 or negedge arst_n) begin
      if (!arst_n) begin
         state      <= BS_IDLE;
         sel_addr_q <= 1'b0;
         addr_wr_q  <= 1'b0;
         data_wr_q  <= 1'b0;
         rd_done_q  <= 1'b0;
         rd_addr_q  <= 1'b0;
         rd_data_q  <= 1'b0;
         reg_addr_q <= 8'h00;
      end else begin
         // Strobes live for one clock only
         addr_wr_q <= 1'b0;
         data_wr_q <= 1'b0;
         rd_done_q <= 1'b0;
         case (state)
            BS_IDLE: begin
               if (start_wr) begin
                  state      <= BS_WRITE;
                  sel_addr_q <= hit_addr_port;
               end else if (start_rd) begin
                  state      <= BS_READ;
                  sel_addr_q <= hit_addr_port;
               end
            end
            BS_WRITE: begin
               addr_wr_q <= sel_addr_q;
               data_wr_q <= !sel_addr_q;
               if (sel_addr_q) begin
                  reg_addr_q <= wdata_q;
               end
               state <= BS_WAIT_END;
            end
            BS_READ: begin
               rd_addr_q <= sel_addr_q;
               rd_data_q <= !sel_addr_q;
               state     <= BS_WAIT_END;
            end
            BS_WAIT_END: begin
               // Hold until the CPU lets go of iorq_n
               if (bus.iorq_n) begin
                  rd_addr_q <= 1'b0;
                  rd_data_q <= 1'b0;
                  rd_done_q <= rd_data_q;
                  state     <= BS_IDLE;
               end
            end
            default: state <= BS_IDLE;
         endcase
      end
   end

   // Write byte taken when the cycle is first seen
   always_ff @(posedge clk28) begin
      if (start_wr) begin
         wdata_q <= bus.data;
      end
   end

   always_comb begin
      access.addr_wr      = addr_wr_q;
      access.data_wr      = data_wr_q;
      access.data_rd_done = rd_done_q;
      access.rd_addr_port = rd_addr_q;
      access.rd_data_port = rd_data_q;
      access.wdata        = wdata_q;
   end

   assign reg_addr        = reg_addr_q;
   assign regaddr_changed = addr_wr_q;

endmodule

`default_nettype wire

// ==== source/coreid_reader.sv ====
`default_nettype none

`include "zxreg_consts.svh"

module coreid_reader
   import zxreg_pkg::*;
(
   input  wire        clk28,
   input  wire        arst_n,
   input  wire        regaddr_changed,
   input  wire        coreid_advance,
   output logic [7:0] coreid_char
);

   localparam int LEN   = `ZXREG_COREID_LEN;
   localparam int PTR_W = (LEN > 1) ? $clog2(LEN) : 1;

   // Last valid character position
   localparam logic [PTR_W-1:0] LAST = PTR_W'(LEN - 1);

   logic [PTR_W-1:0] ptr;

   // ------------------------------------------------------------
   // Character pointer
   // ------------------------------------------------------------
   always_ff @(posedge clk28 or negedge arst_n) begin
      if (!arst_n) begin
         ptr <= '0;
      end else if (regaddr_changed) begin
         // New selection restarts the string, even for the same index
         ptr <= '0;
      end else if (coreid_advance) begin
         if (ptr == LAST) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // String table lookup
   // ------------------------------------------------------------
   always_comb begin
      int base;
      base        = 8 * (LEN - 1 - int'(ptr));
      coreid_char = coreid_text[base +: 8];
   end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none

`include "zxreg_consts.svh"

module reg_file
   import zxreg_pkg::*;
(
   input  wire               clk28,
   input  wire               arst_n,
   input  wire reg_access_t  access,
   input  wire [7:0]         reg_addr,
   input  wire [7:0]         coreid_char,
   output logic              coreid_advance,
   output logic [7:0]        cpu_din,
   output logic              cpu_oe_n,
   output dev_options_t      dev_options,
   output video_ctrl_t       video_ctrl,
   output raster_cfg_t       raster_cfg
);

   logic       wr_devoptions;
   logic       wr_scandbl;
   logic       wr_rasterline;
   logic       wr_rasterctrl;

   // Byte behind the selected index
   logic [7:0] sel_rdata;
   logic [7:0] rasterctrl_rdata;

   // ------------------------------------------------------------
   // Write decode
   // ------------------------------------------------------------
   // Core-ID and unmapped indices get no enable at all
   assign wr_devoptions = access.data_wr && (reg_addr == `ZXREG_IDX_DEVOPTIONS);
   assign wr_scandbl    = access.data_wr && (reg_addr == `ZXREG_IDX_SCANDBL);
   assign wr_rasterline = access.data_wr && (reg_addr == `ZXREG_IDX_RASTERLINE);
   assign wr_rasterctrl = access.data_wr && (reg_addr == `ZXREG_IDX_RASTERCTRL);

   // ------------------------------------------------------------
   // Configuration registers
   // ------------------------------------------------------------
   always_ff @(posedge clk28 or negedge arst_n) begin
      if (!arst_n) begin
         dev_options <= '0;
      end else if (wr_devoptions) begin
         dev_options <= dev_options_t'(access.wdata);
      end
   end

   // All 8 bits stored, spare bit included
   always_ff @(posedge clk28 or negedge arst_n) begin
      if (!arst_n) begin
         video_ctrl <= '0;
      end else if (wr_scandbl) begin
         video_ctrl <= video_ctrl_t'(access.wdata);
      end
   end

   // Line number is split over two registers
   always_ff @(posedge clk28 or negedge arst_n) begin
      if (!arst_n) begin
         raster_cfg <= '0;
      end else begin
         if (wr_rasterline) begin
            raster_cfg.raster_line[7:0] <= access.wdata;
         end
         if (wr_rasterctrl) begin
            raster_cfg.raster_line[8]      <= access.wdata[0];
            raster_cfg.rasterint_enable    <= access.wdata[1];
            raster_cfg.vretraceint_disable <= access.wdata[2];
         end
      end
   end

   // ------------------------------------------------------------
   // Read data selection
   // ------------------------------------------------------------
   // Upper five bits of raster control read as zero
   assign rasterctrl_rdata = {
      5'b00000,
      raster_cfg.vretraceint_disable,
      raster_cfg.rasterint_enable,
      raster_cfg.raster_line[8]
   };

   always_comb begin
      case (reg_addr)
         `ZXREG_IDX_SCANDBL:    sel_rdata = video_ctrl;
         `ZXREG_IDX_RASTERLINE: sel_rdata = raster_cfg.raster_line[7:0];
         `ZXREG_IDX_RASTERCTRL: sel_rdata = rasterctrl_rdata;
         `ZXREG_IDX_DEVOPTIONS: sel_rdata = dev_options;
         `ZXREG_IDX_COREID:     sel_rdata = coreid_char;
         default:               sel_rdata = `ZXREG_UNMAPPED;
      endcase
   end

   // Address port wins, data port next, bus idles high otherwise
   always_comb begin
      if (access.rd_addr_port) begin
         cpu_din = reg_addr;
      end else if (access.rd_data_port) begin
         cpu_din = sel_rdata;
      end else begin
         cpu_din = `ZXREG_UNMAPPED;
      end
   end

   assign cpu_oe_n = !(access.rd_addr_port || access.rd_data_port);

   // Step the string once the CPU has taken its character
   assign coreid_advance = access.data_rd_done && (reg_addr == `ZXREG_IDX_COREID);

endmodule

`default_nettype wire

// ==== source/zxreg_top.sv ====
`default_nettype none

module zxreg_top
   import zxreg_pkg::*;
(
   input  wire              clk28,
   input  wire              arst_n,
   input  wire bus_cycle_t  bus,
   output logic [7:0]       cpu_din,
   output logic             cpu_oe_n,
   output dev_options_t     dev_options,
   output video_ctrl_t      video_ctrl,
   output raster_cfg_t      raster_cfg
);

   reg_access_t access;
   logic [7:0]  reg_addr;
   logic        regaddr_changed;
   logic        coreid_advance;
   logic [7:0]  coreid_char;

   // ------------------------------------------------------------
   // Bus side
   // ------------------------------------------------------------
   bus_cycle_fsm bus_fsm (
      .clk28           (clk28),
      .arst_n          (arst_n),
      .bus             (bus),
      .access          (access),
      .reg_addr        (reg_addr),
      .regaddr_changed (regaddr_changed)
   );

   // ------------------------------------------------------------
   // Registers
   // ------------------------------------------------------------
   coreid_reader core_id (
      .clk28           (clk28),
      .arst_n          (arst_n),
      .regaddr_changed (regaddr_changed),
      .coreid_advance  (coreid_advance),
      .coreid_char     (coreid_char)
   );

   reg_file config_regs (
      .clk28          (clk28),
      .arst_n         (arst_n),
      .access         (access),
      .reg_addr       (reg_addr),
      .coreid_char    (coreid_char),
      .coreid_advance (coreid_advance),
      .cpu_din        (cpu_din),
      .cpu_oe_n       (cpu_oe_n),
      .dev_options    (dev_options),
      .video_ctrl     (video_ctrl),
      .raster_cfg     (raster_cfg)
   );

endmodule

`default_nettype wire

// ==== dv/zxreg_asserts.sv ====
`default_nettype none

module zxreg_asserts
   import zxreg_pkg::*;
(
   input wire              clk28,
   input wire              arst_n,
   input wire reg_access_t access,
   input wire              regaddr_changed
);

   // ------------------------------------------------------------
   // Strobe width
   // ------------------------------------------------------------
   addr_wr_single: assert property (@(posedge clk28) disable iff (!arst_n)
      access.addr_wr |=> !access.addr_wr)
      else $error("addr_wr strobe held longer than one clock");

   data_wr_single: assert property (@(posedge clk28) disable iff (!arst_n)
      access.data_wr |=> !access.data_wr)
      else $error("data_wr strobe held longer than one clock");

   rd_done_single: assert property (@(posedge clk28) disable iff (!arst_n)
      access.data_rd_done |=> !access.data_rd_done)
      else $error("data_rd_done strobe held longer than one clock");

   // ------------------------------------------------------------
   // Exclusive strobes and levels
   // ------------------------------------------------------------
   strobes_exclusive: assert property (@(posedge clk28) disable iff (!arst_n)
      $onehot0({access.addr_wr, access.data_wr, access.data_rd_done}))
      else $error("more than one access strobe high in the same clock");

   read_levels_exclusive: assert property (@(posedge clk28) disable iff (!arst_n)
      !(access.rd_addr_port && access.rd_data_port))
      else $error("address and data read levels high together");

   // Pointer restart must follow every address write
   changed_matches_addr_wr: assert property (@(posedge clk28) disable iff (!arst_n)
      regaddr_changed == access.addr_wr)
      else $error("regaddr_changed does not match addr_wr");

endmodule

`default_nettype wire

// ==== dv/zxreg_tb.sv ====
`default_nettype none

`include "zxreg_consts.svh"

module zxreg_tb
   import zxreg_pkg::*;
;

   localparam int ADDR_TESTS     = 8;
   localparam int REG_TESTS      = 16;
   localparam int COREID_READS   = 12;
   localparam int UNMAPPED_TESTS = 6;
   localparam int FOREIGN_TESTS  = 6;

   // Bus cycles issued by each test, used to size the watchdog
   localparam int NUM_CYCLES = (1 + 2 * 4) + (2 * ADDR_TESTS) + (3 * REG_TESTS)
                             + (2 + COREID_READS + 3) + (3 * UNMAPPED_TESTS)
                             + (2 * FOREIGN_TESTS + 1);

   logic         clk28 = 1'b0;
   logic         arst_n;
   bus_cycle_t   bus;
   logic [7:0]   cpu_din;
   logic         cpu_oe_n;
   dev_options_t dev_options;
   video_ctrl_t  video_ctrl;
   raster_cfg_t  raster_cfg;

   // Reference model state
   logic [7:0]  m_addr;
   logic [7:0]  m_devopt;
   logic [7:0]  m_scandbl;
   logic [8:0]  m_rline;
   logic        m_rint;
   logic        m_vret;
   int          m_ptr;

   // Requests to the comparison process
   logic        chk_read;
   logic        chk_oe_n;
   logic [7:0]  chk_din;
   logic        chk_regs;

   logic [15:0] lfsr;
   int          check_count;
   int          err_count;
   int          checks_mark;
   int          errs_mark;

   zxreg_top dut0 (
      .clk28       (clk28),
      .arst_n      (arst_n),
      .bus         (bus),
      .cpu_din     (cpu_din),
      .cpu_oe_n    (cpu_oe_n),
      .dev_options (dev_options),
      .video_ctrl  (video_ctrl),
      .raster_cfg  (raster_cfg)
   );

   bind bus_cycle_fsm zxreg_asserts fsm_checks (
      .clk28           (clk28),
      .arst_n          (arst_n),
      .access          (access),
      .regaddr_changed (regaddr_changed)
   );

   always #10 clk28 = ~clk28;

   // ------------------------------------------------------------
   // Random source and reference model
   // ------------------------------------------------------------
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[14:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return val;
   endfunction

   function automatic logic is_mapped(input logic [7:0] idx);
      return (idx >= `ZXREG_IDX_SCANDBL && idx <= `ZXREG_IDX_DEVOPTIONS) ||
             (idx == `ZXREG_IDX_COREID);
   endfunction

   function automatic logic [7:0] expected_din(input logic [15:0] port);
      if (port == `ZXREG_ADDR_PORT) begin
         return m_addr;
      end
      case (m_addr)
         `ZXREG_IDX_SCANDBL:    return m_scandbl;
         `ZXREG_IDX_RASTERLINE: return m_rline[7:0];
         `ZXREG_IDX_RASTERCTRL: return {5'b00000, m_vret, m_rint, m_rline[8]};
         `ZXREG_IDX_DEVOPTIONS: return m_devopt;
         `ZXREG_IDX_COREID:     return coreid_text[8 * (`ZXREG_COREID_LEN - 1 - m_ptr) +: 8];
         default:               return `ZXREG_UNMAPPED;
      endcase
   endfunction

   task automatic model_write(input logic [15:0] port, input logic [7:0] data);
      if (port == `ZXREG_ADDR_PORT) begin
         m_addr = data;
         m_ptr  = 0;
      end else if (port == `ZXREG_DATA_PORT) begin
         case (m_addr)
            `ZXREG_IDX_DEVOPTIONS: m_devopt = data;
            `ZXREG_IDX_SCANDBL:    m_scandbl = data;
            `ZXREG_IDX_RASTERLINE: m_rline[7:0] = data;
            `ZXREG_IDX_RASTERCTRL: begin
               m_rline[8] = data[0];
               m_rint     = data[1];
               m_vret     = data[2];
            end
            default: ;
         endcase
      end
   endtask

   // ------------------------------------------------------------
   // Bus cycles, 6 clocks with iorq_n low then 2 idle
   // ------------------------------------------------------------
   task automatic bus_cycle(input logic [15:0] port, input logic [7:0] data, input logic write);
      logic ours;
      ours       = (port == `ZXREG_ADDR_PORT) || (port == `ZXREG_DATA_PORT);
      bus.addr   = port;
      bus.data   = data;
      bus.rd_n   = write;
      bus.wr_n   = !write;
      bus.iorq_n = 1'b0;
      chk_din    = expected_din(port);
      chk_oe_n   = !ours;
      repeat (5) @(posedge clk28);
      #2;
      chk_read = !write;
      @(posedge clk28);
      #2;
      chk_read   = 1'b0;
      bus.iorq_n = 1'b1;
      bus.rd_n   = 1'b1;
      bus.wr_n   = 1'b1;
      if (write) begin
         model_write(port, data);
      end else if (port == `ZXREG_DATA_PORT && m_addr == `ZXREG_IDX_COREID) begin
         m_ptr = (m_ptr + 1) % `ZXREG_COREID_LEN;
      end
      @(posedge clk28);
      #2;
      chk_regs = 1'b1;
      @(posedge clk28);
      #2;
      chk_regs = 1'b0;
   endtask

   task automatic expect_idle_bus();
      chk_oe_n = 1'b1;
      chk_read = 1'b1;
      chk_regs = 1'b1;
      @(posedge clk28);
      #2;
      chk_read = 1'b0;
      chk_regs = 1'b0;
   endtask

   task automatic finish_test(input string name);
      $display("%s: %0d checks, %0d errors", name, check_count - checks_mark,
               err_count - errs_mark);
      checks_mark = check_count;
      errs_mark   = err_count;
   endtask

   // ------------------------------------------------------------
   // Comparison
   // ------------------------------------------------------------
   always @(negedge clk28) begin
      if (chk_read) begin
         check_count++;
         assert (cpu_oe_n == chk_oe_n) else begin
            $display("ERROR cpu_oe_n: got %h, expected %h", cpu_oe_n, chk_oe_n);
            err_count++;
         end
         if (!chk_oe_n) begin
            check_count++;
            assert (cpu_din == chk_din) else begin
               $display("ERROR cpu_din: got %h, expected %h", cpu_din, chk_din);
               err_count++;
            end
         end
      end
      if (chk_regs) begin
         check_count += 3;
         assert (dev_options == m_devopt) else begin
            $display("ERROR dev_options: got %h, expected %h", dev_options, m_devopt);
            err_count++;
         end
         assert (video_ctrl == m_scandbl) else begin
            $display("ERROR video_ctrl: got %h, expected %h", video_ctrl, m_scandbl);
            err_count++;
         end
         assert (raster_cfg == {m_rline, m_rint, m_vret}) else begin
            $display("ERROR raster_cfg: got %h, expected %h", raster_cfg,
                     {m_rline, m_rint, m_vret});
            err_count++;
         end
      end
   end

   initial begin
      repeat (NUM_CYCLES * 8 + 100) @(posedge clk28);
      $display("Timeout: the bus cycles did not complete within the expected time");
      $display("Done: errors found");
      $finish;
   end

   // ------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------
   initial begin
      logic [7:0]  idx;
      logic [15:0] port;
      arst_n     = 1'b0;
      bus        = '{addr: 16'h0000, data: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
      {m_addr, m_devopt, m_scandbl} = '0;
      {m_rline, m_rint, m_vret}     = '0;
      m_ptr      = 0;
      {chk_read, chk_oe_n, chk_din, chk_regs} = '0;
      lfsr       = 16'd31570;
      {check_count, err_count, checks_mark, errs_mark} = '0;
      repeat (8) @(posedge clk28);
      #2;
      arst_n = 1'b1;
      @(posedge clk28);
      #2;

      expect_idle_bus();
      bus_cycle(`ZXREG_ADDR_PORT, 8'h00, 1'b0);
      for (int r = 0; r < 4; r++) begin
         bus_cycle(`ZXREG_ADDR_PORT, `ZXREG_IDX_SCANDBL + 8'(r), 1'b1);
         bus_cycle(`ZXREG_DATA_PORT, 8'h00, 1'b0);
      end
      finish_test("reset values");

      for (int t = 0; t < ADDR_TESTS; t++) begin
         bus_cycle(`ZXREG_ADDR_PORT, 8'(rand_bits(8)), 1'b1);
         bus_cycle(`ZXREG_ADDR_PORT, 8'h00, 1'b0);
      end
      finish_test("address port");

      for (int t = 0; t < REG_TESTS; t++) begin
         idx = `ZXREG_IDX_SCANDBL + 8'(rand_bits(2));
         bus_cycle(`ZXREG_ADDR_PORT, idx, 1'b1);
         bus_cycle(`ZXREG_DATA_PORT, 8'(rand_bits(8)), 1'b1);
         bus_cycle(`ZXREG_DATA_PORT, 8'h00, 1'b0);
      end
      finish_test("register readback");

      bus_cycle(`ZXREG_ADDR_PORT, `ZXREG_IDX_COREID, 1'b1);
      for (int t = 0; t < COREID_READS; t++) begin
         bus_cycle(`ZXREG_DATA_PORT, 8'h00, 1'b0);
      end
      // Same index again, string starts over
      bus_cycle(`ZXREG_ADDR_PORT, `ZXREG_IDX_COREID, 1'b1);
      repeat (3) bus_cycle(`ZXREG_DATA_PORT, 8'h00, 1'b0);
      finish_test("core id");

      for (int t = 0; t < UNMAPPED_TESTS; t++) begin
         idx = 8'(rand_bits(8));
         while (is_mapped(idx)) begin
            idx = 8'(rand_bits(8));
         end
         bus_cycle(`ZXREG_ADDR_PORT, idx, 1'b1);
         bus_cycle(`ZXREG_DATA_PORT, 8'(rand_bits(8)), 1'b1);
         bus_cycle(`ZXREG_DATA_PORT, 8'h00, 1'b0);
      end
      for (int t = 0; t < FOREIGN_TESTS; t++) begin
         port = rand_bits(16);
         while (port == `ZXREG_ADDR_PORT || port == `ZXREG_DATA_PORT) begin
            port = rand_bits(16);
         end
         bus_cycle(port, 8'(rand_bits(8)), 1'b1);
         bus_cycle(port, 8'h00, 1'b0);
      end
      bus_cycle(`ZXREG_ADDR_PORT, 8'h00, 1'b0);
      finish_test("unmapped and foreign");

      $display("Total: %0d checks, %0d errors", check_count, err_count);
      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/zxreg_pkg.sv
source/bus_cycle_fsm.sv
source/coreid_reader.sv
source/reg_file.sv
source/zxreg_top.sv
dv/zxreg_asserts.sv
dv/zxreg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the register subsystem and its testbench with Verilator, then run it.
# The result is taken from the simulation log.

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir "$LOG" "$BUILD_LOG"

verilator --binary --timing --assert -f src.f --top-module zxreg_tb -o zxreg_sim \
   > "$BUILD_LOG" 2>&1 \
   && ./obj_dir/zxreg_sim > "$LOG" 2>&1 \
   && ! grep -q "Done: errors found" "$LOG" \
   && grep -q "Done: no errors" "$LOG" \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see $BUILD_LOG and $LOG"; exit 1; }
